/* bench/conv_chk.sv */
`timescale 1ns/1ns

module conv_chk (
  input logic clk,
  input logic reset,
  input logic coef_we,
  input logic win_valid,
  input logic prod_valid,
  input logic res_valid
);

  // ####################################################################
  // pipeline properties.
  // ####################################################################

  // no result while the pipeline is held in reset.
  a_reset_quiet : assert property (
    @(posedge clk) (reset && $past(reset)) |-> !res_valid
  ) else $error("result valid during reset");

  a_latency : assert property (
    @(posedge clk) disable iff (reset) res_valid == $past(win_valid, 3)
  ) else $error("result valid does not follow win_valid by 3 cycles");

  // kernel stays fixed while products are formed.
  a_coef_quiet : assert property (
    @(posedge clk) disable iff (reset) coef_we |-> !(win_valid || prod_valid)
  ) else $error("coefficient write with a window in flight");

endmodule

bind conv5x5_top conv_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .coef_we   (coef_in.we),
  .win_valid (win_valid),
  .prod_valid(prod_valid),
  .res_valid (res_out.valid)
);

/* bench/conv_tb.sv */
`timescale 1ns/1ns

module conv_tb;

  localparam int IMG_W       = 10;
  localparam int IMG_H       = 8;
  localparam int IMG_PIX     = IMG_W * IMG_H;
  localparam int LATENCY     = 4;  // cycles from drive edge to visible result.
  localparam int GAP_MAX     = 3;
  localparam int DRAIN_LIMIT = 64;
  // pixel beats of all tests plus three kernel loads.
  localparam int TOTAL_BEATS = (4 * IMG_W + 4) + 7 * IMG_PIX + 64 + 3 * (conv_pkg::TAPS + 1);
  localparam int TIMEOUT_NS  = 2 * TOTAL_BEATS * (GAP_MAX + 1) * 8;

  logic                  clk;
  logic                  reset;
  stream_pkg::pix_beat_t pix_in;
  stream_pkg::coef_wr_t  coef_in;
  stream_pkg::res_beat_t res_out;

  conv_pkg::pixel_t frame [IMG_H][IMG_W];
  conv_pkg::coef_t  kern  [conv_pkg::TAPS];
  logic [15:0]      lfsr_state;
  int               cyc = 0;
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  int               outputs = 0;
  int               exp_sum_q [$];
  int               exp_cyc_q [$];

  conv5x5_top #(
    .IMG_W(IMG_W)
  ) uut (
    .clk    (clk),
    .reset  (reset),
    .pix_in (pix_in),
    .coef_in(coef_in),
    .res_out(res_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ####################################################################
  // support code.
  // ####################################################################

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois form with taps 16 14 13 11.
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // sum over the 5x5 neighbourhood ending at (r,c).
  function automatic int ref_sum(input int r, input int c);
    int acc;
    acc = 0;
    for (int i = 0; i < conv_pkg::KSIZE; i++) begin
      for (int j = 0; j < conv_pkg::KSIZE; j++) begin
        acc += int'(frame[r - 4 + i][c - 4 + j]) * int'(kern[i * conv_pkg::KSIZE + j]);
      end
    end
    return acc;
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic fill_frame(input logic use_lfsr, input conv_pkg::pixel_t value);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        frame[r][c] = use_lfsr ? conv_pkg::pixel_t'(rand_bits(8)) : value;
      end
    end
  endtask

  task automatic set_kernel(input logic use_lfsr, input conv_pkg::coef_t value);
    for (int t = 0; t < conv_pkg::TAPS; t++) begin
      kern[t] = use_lfsr ? conv_pkg::coef_t'(rand_bits(8)) : value;
    end
  endtask

  task automatic load_kernel();
    for (int t = 0; t < conv_pkg::TAPS; t++) begin
      @(negedge clk);
      coef_in.we   = 1'b1;
      coef_in.addr = 5'(t);
      coef_in.coef = kern[t];
    end
    @(negedge clk);
    coef_in.addr = 5'd31;  // unused address that must not land in the kernel.
    coef_in.coef = 8'hFF;
    @(negedge clk);
    coef_in = '0;
  endtask

  task automatic send_pixel(input int r, input int c, input logic sof, input int gaps);
    repeat (gaps) begin
      @(negedge clk);
      pix_in = '0;
    end
    @(negedge clk);
    pix_in.valid = 1'b1;
    pix_in.sof   = sof;
    pix_in.pix   = frame[r][c];
    if (r >= 4 && c >= 4) begin
      exp_sum_q.push_back(ref_sum(r, c));
      exp_cyc_q.push_back(cyc);
    end
  endtask

  // sends the first n_pix pixels of the stored frame in raster order.
  task automatic drive_frame(input int n_pix, input int gap_max);
    for (int k = 0; k < n_pix; k++) begin
      send_pixel(k / IMG_W, k % IMG_W, k == 0, (gap_max > 0) ? rand_bits(2) : 0);
    end
    @(negedge clk);
    pix_in = '0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_sum_q.size() > 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_sum_q.size() > 0) begin
      report_failure("expected results never appeared");
    end
    repeat (LATENCY + 2) @(negedge clk);  // room for stray results.
  endtask

  task automatic watch_results();
    forever begin
      @(negedge clk);
      if (!reset && res_out.valid) begin
        outputs++;
        if (exp_sum_q.size() == 0) begin
          report_failure("result appeared with no completed window");
        end else begin
          check_value("res_out.sum", int'(res_out.sum), exp_sum_q.pop_front());
          check_value("res_out.valid latency", cyc - exp_cyc_q.pop_front(), LATENCY);
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int got_outputs, input int exp_outputs);
    check_value({name, " output count"}, got_outputs, exp_outputs);
    tests++;
    $display("test %s finished, %0d outputs, %0d errors so far", name, got_outputs, errors);
  endtask

  // ####################################################################
  // directed tests.
  // ####################################################################

  task automatic test_reset_quiet();
    int start;
    start = outputs;
    fill_frame(1'b1, 8'd0);
    drive_frame(4 * IMG_W + 4, 0);  // one beat short of the first window.
    repeat (2 * LATENCY) @(negedge clk);
    end_test("reset_quiet", outputs - start, 0);
  endtask

  task automatic test_center_tap();
    int start;
    start = outputs;
    set_kernel(1'b0, 8'd0);
    kern[12] = 8'd1;
    load_kernel();
    for (int f = 0; f < 2; f++) begin
      fill_frame(1'b1, 8'd0);
      drive_frame(IMG_PIX, 0);
    end
    wait_drain();
    end_test("center_tap", outputs - start, 48);
  endtask

  task automatic test_full_scale();
    int start;
    start = outputs;
    set_kernel(1'b0, 8'd255);
    load_kernel();
    fill_frame(1'b0, 8'd255);
    check_value("full scale reference", ref_sum(4, 4), 1625625);
    drive_frame(IMG_PIX, 0);
    wait_drain();
    end_test("full_scale", outputs - start, 24);
  endtask

  task automatic test_random();
    int start;
    start = outputs;
    set_kernel(1'b1, 8'd0);
    load_kernel();
    for (int f = 0; f < 2; f++) begin
      fill_frame(1'b1, 8'd0);
      drive_frame(IMG_PIX, 0);
    end
    wait_drain();
    end_test("random", outputs - start, 48);
  endtask

  // replays the last random frame with idle cycles between beats.
  task automatic test_gaps();
    int start;
    start = outputs;
    drive_frame(IMG_PIX, GAP_MAX);
    wait_drain();
    end_test("gaps", outputs - start, 24);
  endtask

  task automatic test_sof_restart();
    int start;
    start = outputs;
    fill_frame(1'b1, 8'd0);
    drive_frame(64, 0);  // stops at row 6 column 3.
    fill_frame(1'b1, 8'd0);
    drive_frame(IMG_PIX, 0);
    wait_drain();
    end_test("sof_restart", outputs - start, 12 + 24);
  endtask

  // ####################################################################
  // main sequence.
  // ####################################################################

  initial begin
    pix_in     = '0;
    coef_in    = '0;
    reset      = 1'b1;
    lfsr_state = 16'd66;
    fork
      watch_results();
    join_none
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_quiet();
    test_center_tap();
    test_full_scale();
    test_random();
    test_gaps();
    test_sof_restart();
    $display("tests %0d, checks %0d, outputs %0d, errors %0d", tests, checks, outputs, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

endmodule

/* logic/adder_tree.sv */
`timescale 1ns/1ns

module adder_tree (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_pkg::prod_vec_t   prods,
  input  logic                  prod_valid,
  output stream_pkg::res_beat_t res_out
);

  localparam int K     = conv_pkg::KSIZE;
  localparam int ROW_W = conv_pkg::PROD_W + 3;  // five products need 3 more bits.

  logic [ROW_W-1:0] row_sum [K];
  logic [ROW_W-1:0] row_q   [K];
  logic             row_valid;

  conv_pkg::sum_t total;
  conv_pkg::sum_t sum_q;
  logic           sum_valid;

  // ####################################################################
  // level one makes one sum per window row.
  // ####################################################################

  always_comb begin
    for (int r = 0; r < K; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < K; c++) begin
        row_sum[r] = row_sum[r] + ROW_W'(prods[r * K + c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      row_q <= row_sum;
    end
  end

  // ####################################################################
  // level two adds the row sums at full width.
  // ####################################################################

  always_comb begin
    total = '0;
    for (int r = 0; r < K; r++) begin
      total = total + conv_pkg::SUM_W'(row_q[r]);
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      sum_q <= total;
    end
  end

  // valid follows the data one stage at a time.
  always_ff @(posedge clk) begin
    if (reset) begin
      row_valid <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      row_valid <= prod_valid;
      sum_valid <= row_valid;
    end
  end

  always_comb begin
    res_out.valid = sum_valid;
    res_out.sum   = sum_q;
  end

endmodule

/* logic/conv5x5_top.sv */
`timescale 1ns/1ns

module conv5x5_top #(
  parameter int IMG_W = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  stream_pkg::pix_beat_t pix_in,
  input  stream_pkg::coef_wr_t  coef_in,
  output stream_pkg::res_beat_t res_out
);

  // window stage to multipliers.
  conv_pkg::window_t win;
  logic              win_valid;

  // multipliers to adder tree.
  conv_pkg::prod_vec_t prods;
  logic                prod_valid;

  // ####################################################################
  // pipeline.
  // ####################################################################

  window_5x5 #(
    .IMG_W(IMG_W)
  ) u_window (
    .clk      (clk),
    .reset    (reset),
    .pix_in   (pix_in),
    .win      (win),
    .win_valid(win_valid)
  );

  conv_mac_array u_mac (
    .clk       (clk),
    .reset     (reset),
    .coef_in   (coef_in),
    .win       (win),
    .win_valid (win_valid),
    .prods     (prods),
    .prod_valid(prod_valid)
  );

  // two registered levels put the result 3 cycles after win_valid.
  adder_tree u_tree (
    .clk       (clk),
    .reset     (reset),
    .prods     (prods),
    .prod_valid(prod_valid),
    .res_out   (res_out)
  );

endmodule

/* logic/conv_mac_array.sv */
`timescale 1ns/1ns

module conv_mac_array (
  input  logic                clk,
  input  logic                reset,
  input  stream_pkg::coef_wr_t coef_in,
  input  conv_pkg::window_t   win,
  input  logic                win_valid,
  output conv_pkg::prod_vec_t prods,
  output logic                prod_valid
);

  conv_pkg::kernel_t   kernel;
  conv_pkg::prod_vec_t prod_comb;

  // ####################################################################
  // kernel registers.
  // ####################################################################

  always_ff @(posedge clk) begin
    if (reset) begin
      kernel <= '0;
    end else if (coef_in.we && (coef_in.addr < 5'(conv_pkg::TAPS))) begin
      kernel[coef_in.addr] <= coef_in.coef;  // addresses past the last tap drop.
    end
  end

  // ####################################################################
  // multipliers.
  // ####################################################################

  for (genvar t = 0; t < conv_pkg::TAPS; t++) begin : g_mult
    shift_mult u_mult (
      .a(win[t]),
      .b(kernel[t]),
      .p(prod_comb[t])
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= win_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      prods <= prod_comb;
    end
  end

endmodule

/* logic/conv_pkg.sv */
package conv_pkg;

  // ####################################################################
  // arithmetic widths.
  // ####################################################################

  parameter int PIX_W  = 8;
  parameter int COEF_W = 8;
  parameter int PROD_W = PIX_W + COEF_W;  // 8x8 unsigned product.
  parameter int SUM_W  = 21;              // 25*255*255 fits in 21 bits.

  // kernel geometry.
  parameter int KSIZE = 5;
  parameter int TAPS  = KSIZE * KSIZE;

  // ####################################################################
  // scalar types.
  // ####################################################################

  typedef logic [PIX_W-1:0]  pixel_t;
  typedef logic [COEF_W-1:0] coef_t;
  typedef logic [PROD_W-1:0] prod_t;
  typedef logic [SUM_W-1:0]  sum_t;

  // ####################################################################
  // vector types indexed by row*KSIZE+col.
  // ####################################################################

  // row 0 is the oldest row and column 0 the oldest column.
  typedef pixel_t [TAPS-1:0] window_t;

  typedef coef_t [TAPS-1:0] kernel_t;  // same tap order as window_t.

  typedef prod_t [TAPS-1:0] prod_vec_t;

endpackage

/* logic/line_delay.sv */
`timescale 1ns/1ns

module line_delay #(
  parameter int DEPTH = 11
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             shift,
  input  conv_pkg::pixel_t din,
  output conv_pkg::pixel_t dout
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  conv_pkg::pixel_t mem [DEPTH];
  logic [PTR_W-1:0] ptr;

  // ####################################################################
  // circular buffer.
  // ####################################################################

  // the slot about to be overwritten holds the oldest pixel.
  assign dout = mem[ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (shift) begin
      mem[ptr] <= din;
      if (ptr == PTR_W'(DEPTH - 1)) begin
        ptr <= '0;  // wrap.
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

endmodule

/* logic/shift_mult.sv */
`timescale 1ns/1ns

module shift_mult (
  input  conv_pkg::pixel_t a,
  input  conv_pkg::coef_t  b,
  output conv_pkg::prod_t  p
);

  // one partial product per multiplier bit.
  conv_pkg::prod_t pp [conv_pkg::COEF_W];

  // ####################################################################
  // partial products.
  // ####################################################################

  for (genvar i = 0; i < conv_pkg::COEF_W; i++) begin : g_pp
    // a shifted to bit i or nothing when b[i] is clear.
    assign pp[i] = b[i] ? (conv_pkg::prod_t'(a) << i) : '0;
  end

  // ####################################################################
  // accumulation.
  // ####################################################################

  // accumulator starts at zero.
  always_comb begin
    p = '0;
    for (int i = 0; i < conv_pkg::COEF_W; i++) begin
      p = p + pp[i];  // 8x8 always fits in 16 bits.
    end
  end

endmodule

/* logic/stream_pkg.sv */
package stream_pkg;

  // ####################################################################
  // stream beats.
  // ####################################################################

  parameter int COEF_ADDR_W = 5;  // covers 25 taps and leaves 25..31 unused.

  // one input pixel where sof marks pixel (0,0).
  typedef struct packed {
    logic            valid;
    logic            sof;
    conv_pkg::pixel_t pix;
  } pix_beat_t;

  // one convolution result.
  typedef struct packed {
    logic          valid;
    conv_pkg::sum_t sum;
  } res_beat_t;

  // ####################################################################
  // kernel loading.
  // ####################################################################

  typedef struct packed {
    logic                   we;
    logic [COEF_ADDR_W-1:0] addr;
    conv_pkg::coef_t        coef;
  } coef_wr_t;

endpackage

/* logic/window_5x5.sv */
`timescale 1ns/1ns

module window_5x5 #(
  parameter int IMG_W = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  stream_pkg::pix_beat_t pix_in,
  output conv_pkg::window_t   win,
  output logic                win_valid
);

  localparam int K     = conv_pkg::KSIZE;
  localparam int COL_W = $clog2(IMG_W);
  localparam int ROW_W = $clog2(K);
  localparam int DEPTH = IMG_W - K;  // 5 window stages plus delay make one line.

  logic [COL_W-1:0] col, col_cur;
  logic [ROW_W-1:0] row, row_cur;

  // pixel entering the newest column of each window row.
  conv_pkg::pixel_t row_in [K];

  // ####################################################################
  // line delays.
  // ####################################################################

  assign row_in[K-1] = pix_in.pix;

  for (genvar k = 0; k < K - 1; k++) begin : g_line
    // oldest pixel of the row below, delayed to line up one row higher.
    line_delay #(
      .DEPTH(DEPTH)
    ) u_line (
      .clk  (clk),
      .reset(reset),
      .shift(pix_in.valid),
      .din  (win[(k + 1) * K]),
      .dout (row_in[k])
    );
  end

  // ####################################################################
  // position tracking.
  // ####################################################################

  // sof forces the current beat to (0,0).
  assign col_cur = pix_in.sof ? '0 : col;
  assign row_cur = pix_in.sof ? '0 : row;

  always_ff @(posedge clk) begin
    if (reset) begin
      col       <= '0;
      row       <= '0;
      win_valid <= 1'b0;
      win       <= '0;
    end else begin
      win_valid <= pix_in.valid && (row_cur == ROW_W'(K - 1)) &&
                   (col_cur >= COL_W'(K - 1));
      if (pix_in.valid) begin
        for (int r = 0; r < K; r++) begin
          for (int c = 0; c < K - 1; c++) begin
            win[r * K + c] <= win[r * K + c + 1];
          end
          win[r * K + K - 1] <= row_in[r];
        end
        if (col_cur == COL_W'(IMG_W - 1)) begin
          col <= '0;
          // row count saturates once full windows are possible.
          row <= (row_cur == ROW_W'(K - 1)) ? row_cur : row_cur + 1'b1;
        end else begin
          col <= col_cur + 1'b1;
          row <= row_cur;
        end
      end
    end
  end

endmodule

/* project.f */
logic/conv_pkg.sv
logic/stream_pkg.sv
logic/shift_mult.sv
logic/line_delay.sv
logic/window_5x5.sv
logic/conv_mac_array.sv
logic/adder_tree.sv
logic/conv5x5_top.sv
bench/conv_chk.sv
bench/conv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module conv_tb -o conv_sim || exit 1

out="$(./obj_dir/conv_sim)"
echo "$out"

echo "$out" | grep -qx "Everything OK" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
